// ==== list.f ====
design/nn_cfg_pkg.sv
design/nn_ctrl_pkg.sv
design/layer_table.sv
design/nn_sequencer.sv
design/load_addr_gen.sv
design/calc_addr_gen.sv
design/result_addr_gen.sv
design/nn_ctrl_top.sv
testbench/nn_ctrl_chk.sv
testbench/tb_nn_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_nn_ctrl
FLAGS     ?= --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f list.f

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_nn_ctrl.sv ====
`timescale 1ns/10ps

module tb_nn_ctrl;

    localparam int n_c        = 2;       // num_neurons
    localparam int timeout_c  = 20000;

    logic pi_clk;
    logic pi_rst;
    logic [15:0] ctrl_signals;
    logic [31:0] num_of_input_nodes;
    logic [31:0] num_of_hidden;
    logic [31:0] num_of_output_nodes;
    logic axis_slave_valid_data;
    logic axis_master_data_stored;
    nn_ctrl_pkg::state_t      fsm_state;
    logic                     wren_stat_reg;
    logic [15:0]              stat_reg_data;
    logic                     axis_slave_data_stored;
    nn_ctrl_pkg::bram_port_t  bram_inp, bram_bia, bram_wei, bram_reg;
    nn_ctrl_pkg::neuron_ctl_t neuron;
    nn_cfg_pkg::node_t        current_layer_nodes;
    logic                     axis_master_write_data;

    int seed = 32'h8fe4_30dd;
    int cycles = 0;
    int fails = 0;
    int checks = 0;
    int layer = 0;
    int beat, k, run, since_en, store_i, sent, clc_cnt, acc_cnt, limit, starts;
    nn_ctrl_pkg::state_t last_state;
    nn_ctrl_pkg::bram_port_t port;

    nn_ctrl_top #(.num_neurons(n_c)) u_dut (.*);

    function automatic int prev_size(input int l);
        int sizes[5] = '{6, 4, 4, 2, 2};
        return sizes[l];
    endfunction

    function automatic int cur_size(input int l);
        int sizes[5] = '{4, 4, 2, 2, 2};
        return sizes[l];
    endfunction

    task automatic check_val(input string name, input int exp, input int got);
        checks++;
        assert (exp == got) else begin
            fails++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    initial begin
        pi_clk = 1'b0;
        forever #20 pi_clk = ~pi_clk;
    end

    // random gaps on both stream strobes
    always @(posedge pi_clk) begin
        #2;
        axis_slave_valid_data   <= ($random(seed) & 3) != 0;
        axis_master_data_stored <= ($random(seed) & 3) != 0;
    end

    always @(posedge pi_clk) begin
        cycles++;
        if (cycles >= timeout_c) begin
            $display("timeout after %0d cycles, network never returned to idle", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(posedge pi_clk) begin
        if (!pi_rst && layer < 5) begin
            if (fsm_state != last_state) beat = 0;
            if (fsm_state inside {nn_ctrl_pkg::LOAD_INPUTS, nn_ctrl_pkg::LOAD_BIASES,
                                  nn_ctrl_pkg::LOAD_WEIGHTS}) begin
                limit = (fsm_state == nn_ctrl_pkg::LOAD_INPUTS) ? prev_size(layer)
                      : (fsm_state == nn_ctrl_pkg::LOAD_BIASES) ? n_c : prev_size(layer) * n_c;
                port  = (fsm_state == nn_ctrl_pkg::LOAD_INPUTS) ? bram_inp
                      : (fsm_state == nn_ctrl_pkg::LOAD_BIASES) ? bram_bia : bram_wei;
                check_val("axis_slave_data_stored", axis_slave_valid_data && beat < limit,
                          axis_slave_data_stored);
                if (axis_slave_data_stored) begin
                    check_val("load_we", 1, port.we);
                    if (fsm_state == nn_ctrl_pkg::LOAD_WEIGHTS) begin
                        check_val("bram_wei.addr", beat % prev_size(layer), port.addr);
                        check_val("bram_wei.lane", beat / prev_size(layer), port.lane);
                    end else begin
                        check_val("load_addr", beat, port.addr);
                    end
                    beat++;
                end
            end
            if (fsm_state == nn_ctrl_pkg::LOAD_INPUTS) store_i = 0;
            if (fsm_state == nn_ctrl_pkg::NEURON_CALC && bram_inp.en) begin
                check_val("bram_inp.addr", k, bram_inp.addr);
                check_val("bram_wei.addr", k, bram_wei.addr);
                k++;
            end else if (fsm_state != nn_ctrl_pkg::NEURON_CALC) begin
                k = 0;
            end
            if (neuron.neuron_en) begin
                run++;
                since_en = 0;
            end else if (!(fsm_state == nn_ctrl_pkg::STORE_RESULT && bram_reg.we)) begin
                since_en++;
            end
            if (neuron.accumulation_done) begin
                check_val("neuron_en run", prev_size(layer), run);
                run = 0;
                acc_cnt++;
            end
            if (neuron.clc_accumulator) begin
                check_val("clc_accumulator gap", 3, since_en);
                clc_cnt++;
            end
            if (fsm_state == nn_ctrl_pkg::STORE_RESULT && bram_reg.we) begin
                check_val("bram_reg.addr", store_i, bram_reg.addr);
                check_val("bram_reg.lane", store_i % n_c, bram_reg.lane);
                store_i++;
            end
            if (fsm_state == nn_ctrl_pkg::SEND_DATA_TO_CPU) begin
                check_val("current_layer_nodes", cur_size(layer), current_layer_nodes);
                // strobe stays up while a word is pending and not taken
                check_val("axis_master_write_data",
                          sent < cur_size(layer) && !axis_master_data_stored,
                          axis_master_write_data);
                if (bram_reg.en) begin
                    check_val("bram_reg.addr", sent, bram_reg.addr);
                    if (axis_master_data_stored) sent++;
                end
            end
            if (wren_stat_reg && fsm_state == nn_ctrl_pkg::IDLE) begin
                check_val("stat_reg_data[0]", 1, stat_reg_data[0]);
                starts++;
            end
            if (wren_stat_reg && fsm_state == nn_ctrl_pkg::SEND_DATA_TO_CPU) begin
                check_val("words sent", cur_size(layer), sent);
                check_val("passes", cur_size(layer) / n_c, clc_cnt);
                check_val("accumulation_done pulses", cur_size(layer) / n_c, acc_cnt);
                check_val("stat_reg_data[0]", layer < 4, stat_reg_data[0]);
                $display("layer %0d done at %0t, checks %0d, fails %0d", layer + 1, $time,
                         checks, fails);
                layer++;
                sent = 0;
                clc_cnt = 0;
                acc_cnt = 0;
            end
        end
        last_state = fsm_state;
    end

    initial begin
        ctrl_signals            = '0;
        num_of_input_nodes      = 32'd6;
        num_of_hidden           = {8'd2, 8'd2, 8'd4, 8'd4};   // hidden 1 in low byte
        num_of_output_nodes     = 32'd2;
        axis_slave_valid_data   = 1'b0;
        axis_master_data_stored = 1'b0;
        pi_rst = 1'b1;
        {beat, k, run, since_en, store_i, sent, clc_cnt, acc_cnt, starts} = '0;
        repeat (8) @(posedge pi_clk);
        #2 pi_rst = 1'b0;
        repeat (4) begin   // OFF with enable low
            @(posedge pi_clk);
            check_val("fsm_state", nn_ctrl_pkg::OFF, fsm_state);
        end
        $display("reset and off state done");
        #2 ctrl_signals[0] = 1'b1;
        while (fsm_state != nn_ctrl_pkg::IDLE) @(posedge pi_clk);
        #2 ctrl_signals[1] = 1'b1;
        while (fsm_state == nn_ctrl_pkg::IDLE) @(posedge pi_clk);
        #2 ctrl_signals[1] = 1'b0;
        $display("start and status pulse done");
        while (layer < 5) @(posedge pi_clk);
        @(posedge pi_clk);
        check_val("fsm_state", nn_ctrl_pkg::IDLE, fsm_state);
        check_val("stat_reg_data[0]", 0, stat_reg_data[0]);
        check_val("start status pulses", 1, starts);
        $display("return to idle done");
        $display("checks %0d, value fails %0d, assertion fails %0d", checks, fails,
                 u_dut.u_chk.fail_cnt);
        if (fails == 0 && u_dut.u_chk.fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== testbench/nn_ctrl_chk.sv ====
`timescale 1ns/10ps

module nn_ctrl_chk (
    input logic                     pi_clk,
    input logic                     pi_rst,
    input nn_ctrl_pkg::state_t      fsm_state,
    input logic                     wren_stat_reg,
    input logic [15:0]              stat_reg_data,
    input logic                     axis_slave_valid_data,
    input logic                     axis_slave_data_stored,
    input logic                     axis_master_data_stored,
    input logic                     axis_master_write_data,
    input nn_ctrl_pkg::bram_port_t  bram_inp,
    input nn_ctrl_pkg::bram_port_t  bram_bia,
    input nn_ctrl_pkg::bram_port_t  bram_wei,
    input nn_ctrl_pkg::bram_port_t  bram_reg,
    input nn_ctrl_pkg::neuron_ctl_t neuron
);

    int fail_cnt = 0;   // read by the testbench for the totals line

    // everything quiet until the network is enabled
    off_quiet: assert property (@(posedge pi_clk) disable iff (pi_rst)
        fsm_state == nn_ctrl_pkg::OFF |-> !(bram_inp.en || bram_bia.en || bram_wei.en
        || bram_reg.en || wren_stat_reg || stat_reg_data[0] || axis_slave_data_stored
        || axis_master_write_data || neuron != '0))
        else begin
            fail_cnt++;
            $error("outputs active while the FSM is OFF");
        end

    stored_needs_valid: assert property (@(posedge pi_clk) disable iff (pi_rst)
        axis_slave_data_stored |-> axis_slave_valid_data)
        else begin
            fail_cnt++;
            $error("slave beat stored without valid");
        end

    acc_done_after_en: assert property (@(posedge pi_clk) disable iff (pi_rst)
        neuron.accumulation_done |-> $past(neuron.neuron_en) && !neuron.neuron_en)
        else begin
            fail_cnt++;
            $error("accumulation_done not right after the last neuron_en");
        end

    clc_in_store: assert property (@(posedge pi_clk) disable iff (pi_rst)
        neuron.clc_accumulator |-> fsm_state == nn_ctrl_pkg::STORE_RESULT && !bram_reg.we)
        else begin
            fail_cnt++;
            $error("accumulator clear outside the store exit cycle");
        end

    master_strobe: assert property (@(posedge pi_clk) disable iff (pi_rst)
        axis_master_write_data |-> !axis_master_data_stored)
        else begin
            fail_cnt++;
            $error("write_data high in a cycle with data_stored");
        end

    drain_two: assert property (@(posedge pi_clk) disable iff (pi_rst)
        fsm_state == nn_ctrl_pkg::WAIT_SIG |=> fsm_state == nn_ctrl_pkg::WAIT_SIG2
        ##1 fsm_state == nn_ctrl_pkg::STORE_RESULT)
        else begin
            fail_cnt++;
            $error("drain did not take two cycles");
        end

    stat_pulse_place: assert property (@(posedge pi_clk) disable iff (pi_rst)
        wren_stat_reg |-> fsm_state inside {nn_ctrl_pkg::IDLE, nn_ctrl_pkg::SEND_DATA_TO_CPU})
        else begin
            fail_cnt++;
            $error("status write outside start or layer end");
        end

endmodule

bind nn_ctrl_top nn_ctrl_chk u_chk (.*);

// ==== design/nn_ctrl_top.sv ====
`timescale 1ns/10ps

module nn_ctrl_top #(
    parameter int num_neurons = 2
) (
    input  logic                     pi_clk,
    input  logic                     pi_rst,
    input  logic [15:0]              ctrl_signals,
    input  logic [31:0]              num_of_input_nodes,
    input  logic [31:0]              num_of_hidden,
    input  logic [31:0]              num_of_output_nodes,
    input  logic                     axis_slave_valid_data,
    input  logic                     axis_master_data_stored,
    output nn_ctrl_pkg::state_t      fsm_state,
    output logic                     wren_stat_reg,
    output logic [15:0]              stat_reg_data,
    output logic                     axis_slave_data_stored,
    output nn_ctrl_pkg::bram_port_t  bram_inp,
    output nn_ctrl_pkg::bram_port_t  bram_bia,
    output nn_ctrl_pkg::bram_port_t  bram_wei,
    output nn_ctrl_pkg::bram_port_t  bram_reg,
    output nn_ctrl_pkg::neuron_ctl_t neuron,
    output nn_cfg_pkg::node_t        current_layer_nodes,
    output logic                     axis_master_write_data
);

    nn_ctrl_pkg::state_t     state;
    nn_cfg_pkg::node_t       prev_nodes;
    nn_cfg_pkg::node_t       cur_nodes;
    logic                    last_layer;
    logic                    layer_step;
    logic                    load_done;
    logic                    calc_done;
    logic                    store_done;
    logic                    send_done;
    logic                    clc_accumulator;
    logic                    neuron_en;
    logic                    accumulation_done;
    nn_ctrl_pkg::bram_port_t load_inp;
    nn_ctrl_pkg::bram_port_t load_bia;
    nn_ctrl_pkg::bram_port_t load_wei;
    nn_ctrl_pkg::bram_port_t calc_inp;
    nn_ctrl_pkg::bram_port_t calc_bia;
    nn_ctrl_pkg::bram_port_t calc_wei;

    layer_table u_layer_table (
        .pi_clk, .pi_rst, .state,
        .num_of_input_nodes, .num_of_hidden, .num_of_output_nodes,
        .layer_step, .prev_nodes, .cur_nodes, .last_layer
    );

    nn_sequencer #(.num_neurons(num_neurons)) u_sequencer (
        .pi_clk, .pi_rst, .ctrl_signals,
        .load_done, .calc_done, .store_done, .send_done, .cur_nodes, .last_layer,
        .state, .layer_step, .wren_stat_reg, .stat_reg_data, .clc_accumulator
    );

    load_addr_gen #(.num_neurons(num_neurons)) u_load (
        .pi_clk, .pi_rst, .state, .axis_slave_valid_data, .prev_nodes,
        .axis_slave_data_stored, .load_done,
        .bram_inp(load_inp), .bram_bia(load_bia), .bram_wei(load_wei)
    );

    calc_addr_gen u_calc (
        .pi_clk, .pi_rst, .state, .prev_nodes,
        .calc_done, .neuron_en, .accumulation_done,
        .bram_inp_rd(calc_inp), .bram_wei_rd(calc_wei), .bram_bia_rd(calc_bia)
    );

    result_addr_gen #(.num_neurons(num_neurons)) u_result (
        .pi_clk, .pi_rst, .state, .cur_nodes, .axis_master_data_stored,
        .store_done, .send_done, .bram_reg, .axis_master_write_data, .current_layer_nodes
    );

    assign fsm_state = state;

    // load writes and calc reads never share a state, so the ports just merge
    assign bram_inp = load_inp | calc_inp;
    assign bram_bia = load_bia | calc_bia;
    assign bram_wei = load_wei | calc_wei;

    assign neuron = '{neuron_en: neuron_en,
                      accumulation_done: accumulation_done,
                      clc_accumulator: clc_accumulator};

endmodule

// ==== design/result_addr_gen.sv ====
`timescale 1ns/10ps

module result_addr_gen #(
    parameter int num_neurons = 2
) (
    input  logic                    pi_clk,
    input  logic                    pi_rst,
    input  nn_ctrl_pkg::state_t     state,
    input  nn_cfg_pkg::node_t       cur_nodes,
    input  logic                    axis_master_data_stored,
    output logic                    store_done,
    output logic                    send_done,
    output nn_ctrl_pkg::bram_port_t bram_reg,
    output logic                    axis_master_write_data,
    output nn_cfg_pkg::node_t       current_layer_nodes
);

    nn_cfg_pkg::addr_t reg_addr;   // runs across all passes of a layer
    nn_cfg_pkg::node_t lane_cnt;
    nn_cfg_pkg::node_t rd_cnt;
    logic              in_store;
    logic              in_send;
    logic              store_wr;
    logic              send_rd;

    assign in_store   = (state == nn_ctrl_pkg::STORE_RESULT);
    assign in_send    = (state == nn_ctrl_pkg::SEND_DATA_TO_CPU);
    assign store_done = in_store && (lane_cnt == nn_cfg_pkg::node_t'(num_neurons));
    assign store_wr   = in_store && !store_done;
    assign send_done  = in_send && (rd_cnt == cur_nodes);
    assign send_rd    = in_send && !send_done;

    // strobe drops in the same cycle the word is taken
    assign axis_master_write_data = send_rd && !axis_master_data_stored;
    assign current_layer_nodes    = cur_nodes;

    always_ff @(posedge pi_clk) begin
        if (pi_rst) begin
            reg_addr <= '0;
            lane_cnt <= '0;
            rd_cnt   <= '0;
        end else begin
            lane_cnt <= store_wr ? lane_cnt + 1'b1 : '0;
            if (store_wr) begin
                reg_addr <= reg_addr + 1'b1;
            end else if (in_send) begin
                reg_addr <= '0;   // layer results are out, next layer stores from 0
            end
            if (!in_send) begin
                rd_cnt <= '0;
            end else if (send_rd && axis_master_data_stored) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        bram_reg = '0;
        if (store_wr) begin
            bram_reg = '{en: 1'b1, we: 1'b1, addr: reg_addr, lane: lane_cnt};
        end else if (send_rd) begin
            // port A read only
            bram_reg = '{en: 1'b1, we: 1'b0, addr: nn_cfg_pkg::addr_t'(rd_cnt), lane: '0};
        end
    end

endmodule

// ==== design/calc_addr_gen.sv ====
`timescale 1ns/10ps

module calc_addr_gen (
    input  logic                    pi_clk,
    input  logic                    pi_rst,
    input  nn_ctrl_pkg::state_t     state,
    input  nn_cfg_pkg::node_t       prev_nodes,
    output logic                    calc_done,
    output logic                    neuron_en,
    output logic                    accumulation_done,
    output nn_ctrl_pkg::bram_port_t bram_inp_rd,
    output nn_ctrl_pkg::bram_port_t bram_wei_rd,
    output nn_ctrl_pkg::bram_port_t bram_bia_rd
);

    nn_cfg_pkg::node_t       k_cnt;
    nn_ctrl_pkg::bram_port_t rd_port;
    logic                    in_calc;
    logic                    rd_active;

    assign in_calc   = (state == nn_ctrl_pkg::NEURON_CALC);
    assign calc_done = in_calc && (k_cnt == prev_nodes);   // exit cycle
    assign rd_active = in_calc && !calc_done;

    always_ff @(posedge pi_clk) begin
        if (pi_rst) begin
            k_cnt             <= '0;
            neuron_en         <= 1'b0;
            accumulation_done <= 1'b0;
        end else begin
            k_cnt             <= rd_active ? k_cnt + 1'b1 : '0;
            neuron_en         <= rd_active;                // bram data lags its address by one
            accumulation_done <= neuron_en && !rd_active;  // one pulse after the last product
        end
    end

    always_comb begin
        rd_port = '0;
        if (rd_active) begin
            rd_port = '{en: 1'b1, we: 1'b0, addr: nn_cfg_pkg::addr_t'(k_cnt), lane: '0};
        end
    end

    assign bram_inp_rd = rd_port;
    assign bram_wei_rd = rd_port;   // lane 0, all lanes read word k together
    assign bram_bia_rd = rd_port;   // neuron j picks its bias up as word j goes by

endmodule

// ==== design/load_addr_gen.sv ====
`timescale 1ns/10ps

module load_addr_gen #(
    parameter int num_neurons = 2
) (
    input  logic                    pi_clk,
    input  logic                    pi_rst,
    input  nn_ctrl_pkg::state_t     state,
    input  logic                    axis_slave_valid_data,
    input  nn_cfg_pkg::node_t       prev_nodes,
    output logic                    axis_slave_data_stored,
    output logic                    load_done,
    output nn_ctrl_pkg::bram_port_t bram_inp,
    output nn_ctrl_pkg::bram_port_t bram_bia,
    output nn_ctrl_pkg::bram_port_t bram_wei
);

    nn_cfg_pkg::node_t       word_cnt;
    nn_cfg_pkg::node_t       lane_cnt;   // only moves for weights
    nn_ctrl_pkg::bram_port_t wr_port;
    logic                    in_load;
    logic                    accept;
    logic                    word_wrap;

    assign in_load = state inside {nn_ctrl_pkg::LOAD_INPUTS, nn_ctrl_pkg::LOAD_BIASES,
                                   nn_ctrl_pkg::LOAD_WEIGHTS};

    always_comb begin
        case (state)
            nn_ctrl_pkg::LOAD_INPUTS:  load_done = (word_cnt == prev_nodes);
            nn_ctrl_pkg::LOAD_BIASES:  load_done = (word_cnt == nn_cfg_pkg::node_t'(num_neurons));
            nn_ctrl_pkg::LOAD_WEIGHTS: load_done = (lane_cnt == nn_cfg_pkg::node_t'(num_neurons));
            default:                   load_done = 1'b0;
        endcase
    end

    assign accept                 = in_load && axis_slave_valid_data && !load_done;
    assign axis_slave_data_stored = accept;

    // weight words fill one lane over the previous layer, then step to the next lane
    assign word_wrap = (state == nn_ctrl_pkg::LOAD_WEIGHTS) && (word_cnt == prev_nodes - 1'b1);

    always_ff @(posedge pi_clk) begin
        if (pi_rst) begin
            word_cnt <= '0;
            lane_cnt <= '0;
        end else if (!in_load || load_done) begin
            word_cnt <= '0;   // next phase starts from word 0
            lane_cnt <= '0;
        end else if (accept) begin
            if (word_wrap) begin
                word_cnt <= '0;
                lane_cnt <= lane_cnt + 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        wr_port = '0;
        if (accept) begin
            wr_port = '{en: 1'b1, we: 1'b1, addr: nn_cfg_pkg::addr_t'(word_cnt), lane: lane_cnt};
        end
        bram_inp = (state == nn_ctrl_pkg::LOAD_INPUTS)  ? wr_port : '0;
        bram_bia = (state == nn_ctrl_pkg::LOAD_BIASES)  ? wr_port : '0;
        bram_wei = (state == nn_ctrl_pkg::LOAD_WEIGHTS) ? wr_port : '0;
    end

endmodule

// ==== design/nn_sequencer.sv ====
`timescale 1ns/10ps

module nn_sequencer #(
    parameter int num_neurons = 2
) (
    input  logic                pi_clk,
    input  logic                pi_rst,
    input  logic [15:0]         ctrl_signals,
    input  logic                load_done,
    input  logic                calc_done,
    input  logic                store_done,
    input  logic                send_done,
    input  nn_cfg_pkg::node_t   cur_nodes,
    input  logic                last_layer,
    output nn_ctrl_pkg::state_t state,
    output logic                layer_step,
    output logic                wren_stat_reg,
    output logic [15:0]         stat_reg_data,
    output logic                clc_accumulator
);

    nn_ctrl_pkg::state_t state_nxt;
    nn_cfg_pkg::node_t   pass_cnt;
    logic                nn_enable;
    logic                start;
    logic                last_pass;
    logic                busy;
    logic                busy_nxt;

    assign nn_enable = ctrl_signals[0];
    assign start     = ctrl_signals[1];

    // a layer takes cur_nodes / num_neurons passes
    assign last_pass = (pass_cnt == cur_nodes / nn_cfg_pkg::node_t'(num_neurons) - 1'b1);

    // last store cycle clears the accumulators
    assign clc_accumulator = (state == nn_ctrl_pkg::STORE_RESULT) && store_done;

    always_comb begin
        state_nxt     = state;
        busy_nxt      = busy;
        wren_stat_reg = 1'b0;
        layer_step    = 1'b0;
        case (state)
            nn_ctrl_pkg::OFF: if (nn_enable) state_nxt = nn_ctrl_pkg::IDLE;
            nn_ctrl_pkg::IDLE: begin
                if (start) begin
                    state_nxt     = nn_ctrl_pkg::SET_LAYERS_INFO;
                    busy_nxt      = 1'b1;
                    wren_stat_reg = 1'b1;
                end
            end
            nn_ctrl_pkg::SET_LAYERS_INFO: state_nxt = nn_ctrl_pkg::LOAD_INPUTS;
            nn_ctrl_pkg::LOAD_INPUTS:  if (load_done) state_nxt = nn_ctrl_pkg::LOAD_BIASES;
            nn_ctrl_pkg::LOAD_BIASES:  if (load_done) state_nxt = nn_ctrl_pkg::LOAD_WEIGHTS;
            nn_ctrl_pkg::LOAD_WEIGHTS: if (load_done) state_nxt = nn_ctrl_pkg::NEURON_CALC;
            nn_ctrl_pkg::NEURON_CALC:  if (calc_done) state_nxt = nn_ctrl_pkg::WAIT_SIG;
            nn_ctrl_pkg::WAIT_SIG:     state_nxt = nn_ctrl_pkg::WAIT_SIG2;   // bram and adder drain
            nn_ctrl_pkg::WAIT_SIG2:    state_nxt = nn_ctrl_pkg::STORE_RESULT;
            nn_ctrl_pkg::STORE_RESULT: begin
                if (store_done) begin
                    state_nxt = last_pass ? nn_ctrl_pkg::SEND_DATA_TO_CPU
                                          : nn_ctrl_pkg::LOAD_BIASES;
                end
            end
            nn_ctrl_pkg::SEND_DATA_TO_CPU: begin
                if (send_done) begin
                    wren_stat_reg = 1'b1;
                    layer_step    = 1'b1;
                    if (last_layer) begin
                        state_nxt = nn_ctrl_pkg::IDLE;
                        busy_nxt  = 1'b0;   // network done
                    end else begin
                        state_nxt = nn_ctrl_pkg::PREPARE_INPUTS;
                    end
                end
            end
            nn_ctrl_pkg::PREPARE_INPUTS: state_nxt = nn_ctrl_pkg::LOAD_INPUTS;
            default: state_nxt = nn_ctrl_pkg::OFF;
        endcase
    end

    always_ff @(posedge pi_clk) begin
        if (pi_rst) begin
            state    <= nn_ctrl_pkg::OFF;
            busy     <= 1'b0;
            pass_cnt <= '0;
        end else begin
            state <= state_nxt;
            busy  <= busy_nxt;
            if (state == nn_ctrl_pkg::LOAD_INPUTS) begin
                pass_cnt <= '0;
            end else if (clc_accumulator) begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    // status word carries the busy value being written with the pulse
    assign stat_reg_data = {15'h0000, busy_nxt};

endmodule

// ==== design/layer_table.sv ====
`timescale 1ns/10ps

module layer_table (
    input  logic                pi_clk,
    input  logic                pi_rst,
    input  nn_ctrl_pkg::state_t state,
    input  logic [31:0]         num_of_input_nodes,
    input  logic [31:0]         num_of_hidden,
    input  logic [31:0]         num_of_output_nodes,
    input  logic                layer_step,
    output nn_cfg_pkg::node_t   prev_nodes,
    output nn_cfg_pkg::node_t   cur_nodes,
    output logic                last_layer
);

    nn_cfg_pkg::hidden_sizes_t hidden;
    nn_cfg_pkg::node_t         prev_tab [nn_cfg_pkg::num_layers_c];
    nn_cfg_pkg::node_t         cur_tab  [nn_cfg_pkg::num_layers_c];
    nn_cfg_pkg::layer_idx_t    layer_idx;   // 0 is hidden layer 1

    assign hidden = nn_cfg_pkg::hidden_sizes_t'(num_of_hidden);

    // follows the register map while idle, so the start edge is the last load
    always_ff @(posedge pi_clk) begin
        if (state == nn_ctrl_pkg::IDLE) begin
            prev_tab[0] <= nn_cfg_pkg::node_t'(num_of_input_nodes);
            prev_tab[1] <= nn_cfg_pkg::node_t'(hidden.hidden1);
            prev_tab[2] <= nn_cfg_pkg::node_t'(hidden.hidden2);
            prev_tab[3] <= nn_cfg_pkg::node_t'(hidden.hidden3);
            prev_tab[4] <= nn_cfg_pkg::node_t'(hidden.hidden4);
            cur_tab[0]  <= nn_cfg_pkg::node_t'(hidden.hidden1);
            cur_tab[1]  <= nn_cfg_pkg::node_t'(hidden.hidden2);
            cur_tab[2]  <= nn_cfg_pkg::node_t'(hidden.hidden3);
            cur_tab[3]  <= nn_cfg_pkg::node_t'(hidden.hidden4);
            cur_tab[4]  <= nn_cfg_pkg::node_t'(num_of_output_nodes);
        end
    end

    always_ff @(posedge pi_clk) begin
        if (pi_rst || state == nn_ctrl_pkg::IDLE) begin
            layer_idx <= '0;
        end else if (layer_step && !last_layer) begin
            layer_idx <= layer_idx + 1'b1;   // held on the output layer until idle
        end
    end

    assign last_layer = (layer_idx == nn_cfg_pkg::layer_idx_t'(nn_cfg_pkg::num_layers_c - 1));
    assign prev_nodes = prev_tab[layer_idx];
    assign cur_nodes  = cur_tab[layer_idx];

endmodule

// ==== design/nn_ctrl_pkg.sv ====
package nn_ctrl_pkg;

    // code is visible to software through fsm_state
    typedef enum logic [3:0] {
        OFF              = 4'd0,
        IDLE             = 4'd1,
        SET_LAYERS_INFO  = 4'd2,
        LOAD_INPUTS      = 4'd3,
        LOAD_BIASES      = 4'd4,
        LOAD_WEIGHTS     = 4'd5,
        NEURON_CALC      = 4'd6,
        WAIT_SIG         = 4'd7,
        WAIT_SIG2        = 4'd8,
        STORE_RESULT     = 4'd9,
        SEND_DATA_TO_CPU = 4'd10,
        PREPARE_INPUTS   = 4'd11
    } state_t;

    // single bram port, lane picks the neuron slice of a split memory
    typedef struct packed {
        logic              en;
        logic              we;
        nn_cfg_pkg::addr_t addr;
        nn_cfg_pkg::node_t lane;
    } bram_port_t;

    typedef struct packed {
        logic neuron_en;
        logic accumulation_done;
        logic clc_accumulator;
    } neuron_ctl_t;

endpackage

// ==== design/nn_cfg_pkg.sv ====
package nn_cfg_pkg;

    localparam int num_layers_c = 5;   // four hidden layers and the output layer
    localparam int node_w_c     = 10;
    localparam int addr_w_c     = 11;

    typedef logic [node_w_c-1:0] node_t;
    typedef logic [2:0]          layer_idx_t;
    typedef logic [addr_w_c-1:0] addr_t;

    // hidden layer sizes as the cpu writes them, hidden layer 1 in the low byte
    typedef struct packed {
        logic [7:0] hidden4;
        logic [7:0] hidden3;
        logic [7:0] hidden2;
        logic [7:0] hidden1;
    } hidden_sizes_t;

endpackage
